/* filelist.f */
src/bpu_pkg.sv
src/pred_table.sv
src/bpu_apb_regs.sv
src/bpu_ctrl.sv
src/bpu_top.sv
sim/bpu_checker.sv
sim/bpu_tb.sv

/* Bender.yml */
package:
  name: bpu

sources:
  # rtl
  - files:
      - src/bpu_pkg.sv
      - src/pred_table.sv
      - src/bpu_apb_regs.sv
      - src/bpu_ctrl.sv
      - src/bpu_top.sv

  # sim
  - target: simulation
    files:
      - sim/bpu_checker.sv
      - sim/bpu_tb.sv

/* sim/bpu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bpu testbench
// table driven lookups, resolves and APB accesses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bpu_tb;

    import bpu_pkg::*;

    localparam logic [2:0] OP_LOOKUP  = 3'd0;
    localparam logic [2:0] OP_RESOLVE = 3'd1;
    localparam logic [2:0] OP_WR      = 3'd2;
    localparam logic [2:0] OP_RD      = 3'd3;
    localparam logic [2:0] OP_IDLE    = 3'd4;

    localparam logic [31:0] PC_A = 32'h0000_1040;
    localparam logic [31:0] PC_B = 32'h0000_1440;   // same index, other tag

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic [7:0]  addr;
        logic [31:0] data;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] lookup_pc;
    lookup_rsp_t lookup_rsp;
    resolve_t    resolve;
    logic        mispredict;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    int          error_count;
    row_t        rows[$];
    logic        rows_built = 1'b0;
    logic        last_taken;
    logic [31:0] last_target;

    bpu_top bpu_top_inst (
        .clk(clk), .rst_n(rst_n), .lookup_pc(lookup_pc), .lookup_rsp(lookup_rsp),
        .resolve(resolve), .mispredict(mispredict), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    bpu_checker u_checker (
        .clk(clk), .rst_n(rst_n), .lookup_pc(lookup_pc), .lookup_rsp(lookup_rsp),
        .resolve(resolve), .mispredict(mispredict), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .error_count(error_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_row(input logic [2:0] op, input logic [31:0] pc, input logic tkn,
                           input logic [31:0] tgt, input logic [7:0] addr,
                           input logic [31:0] data);
        rows.push_back('{op, pc, tkn, tgt, addr, data});
    endtask

    // lookup then resolve, the resolve carries the prediction back
    task automatic add_branch(input logic [31:0] pc, input logic tkn, input logic [31:0] tgt);
        add_row(OP_LOOKUP, pc, 1'b0, '0, '0, '0);
        add_row(OP_RESOLVE, pc, tkn, tgt, '0, '0);
        add_row(OP_LOOKUP, pc, 1'b0, '0, '0, '0);
    endtask

    task automatic build_rows();
        for (int i = 0; i < 6; i++) add_row(OP_LOOKUP, $urandom & 32'hffff_fffc, 0, 0, 0, 0);
        add_branch(PC_A, 1'b1, 32'h0000_2000);                  // taken after one resolve
        repeat (3) add_branch(PC_A, 1'b1, 32'h0000_2000);       // up to strong_t and stay
        repeat (2) add_branch(PC_A, 1'b0, 32'h0);               // back to weak_nt
        repeat (3) add_branch(PC_A, 1'b0, 32'h0);               // floor at strong_nt
        repeat (3) add_branch(PC_A, 1'b1, 32'h0000_2000);
        add_branch(PC_B, 1'b0, 32'h0);                          // alias, btb tag miss
        add_branch(PC_B, 1'b1, 32'h0000_3000);
        add_branch(PC_A, 1'b1, 32'h0000_2400);                  // tag now belongs to PC_B
        add_branch(PC_A, 1'b1, 32'h0000_2800);                  // wrong target
        add_row(OP_IDLE, 0, 0, 0, 0, 0);
        add_row(OP_RD, 0, 0, 0, REG_RESOLVES, 0);
        add_row(OP_RD, 0, 0, 0, REG_MISSES, 0);
        add_row(OP_WR, 0, 0, 0, REG_CTRL, 32'h0);               // prediction off
        add_row(OP_RD, 0, 0, 0, REG_CTRL, 0);
        repeat (2) add_branch(PC_A, 1'b1, 32'h0000_2800);
        add_row(OP_WR, 0, 0, 0, REG_CTRL, 32'h1);
        add_branch(PC_A, 1'b1, 32'h0000_2800);
        add_row(OP_WR, 0, 0, 0, REG_CTRL, 32'h3);               // enable and flush
        add_row(OP_IDLE, 0, 0, 0, 0, 0);
        add_row(OP_LOOKUP, PC_A, 0, 0, 0, 0);
        add_row(OP_LOOKUP, PC_B, 0, 0, 0, 0);
        add_row(OP_RD, 0, 0, 0, 8'h0c, 0);                      // unmapped
        add_row(OP_WR, 0, 0, 0, 8'h10, 32'hdead_beef);
        add_row(OP_WR, 0, 0, 0, REG_RESOLVES, 0);
        add_row(OP_WR, 0, 0, 0, REG_MISSES, 0);
        add_row(OP_RD, 0, 0, 0, REG_RESOLVES, 0);
        add_row(OP_RD, 0, 0, 0, REG_MISSES, 0);
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        resolve.valid <= 1'b0;
        apb_req <= '0;
        case (r.op)
            OP_LOOKUP: lookup_pc <= r.pc;
            OP_RESOLVE: resolve <= {1'b1, r.pc, r.taken, r.target, last_taken, last_target};
            OP_WR, OP_RD: begin
                apb_req <= {1'b1, 1'b0, r.op == OP_WR, r.addr, r.data};
                @(posedge clk);
                apb_req.penable <= 1'b1;
            end
            default: ;
        endcase
        if (r.op == OP_LOOKUP) begin
            @(negedge clk);
            last_taken = lookup_rsp.taken;
            last_target = lookup_rsp.target;
        end
    endtask

    // watchdog, at most two cycles per row plus reset and drain
    initial begin
        wait (rows_built);
        #(rows.size() * 40 + 2000);
        $display("timeout: stimulus did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        lookup_pc = '0;
        resolve = '0;
        apb_req = '0;
        last_taken = 1'b0;
        last_target = '0;
        void'($urandom(30));
        build_rows();
        rows_built = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) apply_row(rows[i]);
        @(posedge clk);
        resolve.valid <= 1'b0;
        apb_req <= '0;
        repeat (4) @(posedge clk);
        $display("run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sim/bpu_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bpu checker
// reference model of counters, valid bits and btb
// that compares lookup, mispredict and APB responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bpu_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          lookup_pc,
    input  bpu_pkg::lookup_rsp_t lookup_rsp,
    input  bpu_pkg::resolve_t    resolve,
    input  logic                 mispredict,
    input  bpu_pkg::apb_req_t    apb_req,
    input  bpu_pkg::apb_rsp_t    apb_rsp,
    output int                   error_count
);

    import bpu_pkg::*;

    int          ctr [TABLE_DEPTH];
    logic        bht_v [TABLE_DEPTH];
    logic        btb_v [TABLE_DEPTH];
    logic [21:0] btb_tag [TABLE_DEPTH];
    logic [31:0] btb_tgt [TABLE_DEPTH];
    logic        en;
    logic        flush_pend;
    logic        exp_miss;
    logic        res_pend;
    logic [31:0] res_cnt;
    logic [31:0] miss_cnt;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    initial error_count = 0;

    always @(negedge clk) begin
        int          idx;
        int          ridx;
        logic        hit;
        logic        tkn;
        logic        access;
        logic        miss_now;
        logic [31:0] rd_exp;
        idx  = lookup_pc[9:2];
        ridx = resolve.pc[9:2];
        if (!rst_n) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                bht_v[i] = 1'b0;
                btb_v[i] = 1'b0;
            end
            en = 1'b1;
            flush_pend = 1'b0;
            exp_miss = 1'b0;
            res_pend = 1'b0;
            res_cnt = '0;
            miss_cnt = '0;
        end else begin
            // lookup against the model
            hit = btb_v[idx] && (btb_tag[idx] == lookup_pc[31:10]);
            tkn = en && bht_v[idx] && (ctr[idx] >= 2) && hit;
            check_val("lookup_rsp.hit", lookup_rsp.hit, hit);
            check_val("lookup_rsp.taken", lookup_rsp.taken, tkn);
            check_val("lookup_rsp.target", lookup_rsp.target,
                      tkn ? btb_tgt[idx] : lookup_pc + 32'd4);
            check_val("mispredict", mispredict, exp_miss);

            access = apb_req.psel && apb_req.penable;
            if (access) begin
                case (apb_req.paddr)
                    8'h00:   rd_exp = {31'd0, en};
                    8'h04:   rd_exp = res_cnt;
                    8'h08:   rd_exp = miss_cnt;
                    default: rd_exp = 32'd0;
                endcase
                check_val("apb_rsp.pready", apb_rsp.pready, 1'b1);   // no wait states
                check_val("apb_rsp.pslverr", apb_rsp.pslverr,
                          !(apb_req.paddr == 8'h00 || apb_req.paddr == 8'h04 ||
                            apb_req.paddr == 8'h08));
                if (!apb_req.pwrite) check_val("apb_rsp.prdata", apb_rsp.prdata, rd_exp);
            end

            // counters move one edge after their strobes
            miss_now = resolve.valid && ((resolve.taken != resolve.pred_taken) ||
                       (resolve.taken && resolve.target != resolve.pred_target));
            if (access && apb_req.pwrite && apb_req.paddr == 8'h04) res_cnt = '0;
            else if (res_pend) res_cnt = res_cnt + 1;
            if (access && apb_req.pwrite && apb_req.paddr == 8'h08) miss_cnt = '0;
            else if (exp_miss) miss_cnt = miss_cnt + 1;
            res_pend = resolve.valid;
            exp_miss = miss_now;

            // a pending flush drops this resolve
            if (flush_pend) begin
                for (int i = 0; i < TABLE_DEPTH; i++) begin
                    bht_v[i] = 1'b0;
                    btb_v[i] = 1'b0;
                end
            end else if (resolve.valid) begin
                if (!bht_v[ridx]) ctr[ridx] = resolve.taken ? 2 : 1;
                else if (resolve.taken) ctr[ridx] = (ctr[ridx] == 3) ? 3 : ctr[ridx] + 1;
                else ctr[ridx] = (ctr[ridx] == 0) ? 0 : ctr[ridx] - 1;
                bht_v[ridx] = 1'b1;
                if (resolve.taken) begin
                    btb_v[ridx] = 1'b1;
                    btb_tag[ridx] = resolve.pc[31:10];
                    btb_tgt[ridx] = resolve.target;
                end
            end
            flush_pend = access && apb_req.pwrite && apb_req.paddr == 8'h00 &&
                         apb_req.pwdata[1];
            if (access && apb_req.pwrite && apb_req.paddr == 8'h00) en = apb_req.pwdata[0];
        end
    end

endmodule

/* src/bpu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch prediction unit top
// controller, bht, btb and APB register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bpu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          lookup_pc,
    output bpu_pkg::lookup_rsp_t lookup_rsp,
    input  bpu_pkg::resolve_t    resolve,
    output logic                 mispredict,
    input  bpu_pkg::apb_req_t    apb_req,
    output bpu_pkg::apb_rsp_t    apb_rsp
);

    import bpu_pkg::*;

    logic                  enable;
    logic                  flush;
    logic                  resolve_evt;
    logic                  miss_evt;
    logic [INDEX_BITS-1:0] rd_a_idx;
    logic [INDEX_BITS-1:0] rd_b_idx;
    logic [INDEX_BITS-1:0] wr_idx;
    bht_entry_t            bht_a;
    bht_entry_t            bht_b;
    bht_entry_t            bht_wr_data;
    btb_entry_t            btb_a;
    btb_entry_t            btb_wr_data;
    logic                  bht_a_valid;
    logic                  bht_b_valid;
    logic                  btb_a_valid;
    logic                  bht_wr_en;
    logic                  btb_wr_en;

    bpu_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .lookup_pc   (lookup_pc),
        .lookup_rsp  (lookup_rsp),
        .resolve     (resolve),
        .mispredict  (mispredict),
        .resolve_evt (resolve_evt),
        .miss_evt    (miss_evt),
        .rd_a_idx    (rd_a_idx),
        .rd_b_idx    (rd_b_idx),
        .bht_a       (bht_a),
        .bht_b       (bht_b),
        .bht_a_valid (bht_a_valid),
        .bht_b_valid (bht_b_valid),
        .btb_a       (btb_a),
        .btb_a_valid (btb_a_valid),
        .bht_wr_en   (bht_wr_en),
        .bht_wr_data (bht_wr_data),
        .btb_wr_en   (btb_wr_en),
        .btb_wr_data (btb_wr_data),
        .wr_idx      (wr_idx)
    );

    pred_table #(.entry_t(bht_entry_t)) u_bht (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .rd_a_data  (bht_a),
        .rd_b_data  (bht_b),
        .rd_a_valid (bht_a_valid),
        .rd_b_valid (bht_b_valid),
        .wr_en      (bht_wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (bht_wr_data)
    );

    // btb is only read on the lookup side
    pred_table #(.entry_t(btb_entry_t)) u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .rd_a_data  (btb_a),
        .rd_b_data  (),
        .rd_a_valid (btb_a_valid),
        .rd_b_valid (),
        .wr_en      (btb_wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (btb_wr_data)
    );

    bpu_apb_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .resolve_evt (resolve_evt),
        .miss_evt    (miss_evt),
        .enable      (enable),
        .flush       (flush)
    );

endmodule

/* src/bpu_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bpu controller
// lookup prediction, counter training, btb fill
// and misprediction detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bpu_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           enable,

    input  logic [31:0]                    lookup_pc,
    output bpu_pkg::lookup_rsp_t           lookup_rsp,
    input  bpu_pkg::resolve_t              resolve,
    output logic                           mispredict,
    output logic                           resolve_evt,
    output logic                           miss_evt,

    // table read ports, a = lookup, b = resolve
    output logic [bpu_pkg::INDEX_BITS-1:0] rd_a_idx,
    output logic [bpu_pkg::INDEX_BITS-1:0] rd_b_idx,
    input  bpu_pkg::bht_entry_t            bht_a,
    input  bpu_pkg::bht_entry_t            bht_b,
    input  logic                           bht_a_valid,
    input  logic                           bht_b_valid,
    input  bpu_pkg::btb_entry_t            btb_a,
    input  logic                           btb_a_valid,

    // table write ports, shared index
    output logic                           bht_wr_en,
    output bpu_pkg::bht_entry_t            bht_wr_data,
    output logic                           btb_wr_en,
    output bpu_pkg::btb_entry_t            btb_wr_data,
    output logic [bpu_pkg::INDEX_BITS-1:0] wr_idx
);

    import bpu_pkg::*;

    logic btb_hit;
    logic pred_taken;
    logic miss;
    logic mispredict_q;
    logic resolve_evt_q;

    // next counter state for one resolved branch
    function automatic ctr_t ctr_next(input ctr_t cur, input logic vld, input logic tkn);
        ctr_t nxt;
        if (!vld) begin
            nxt = tkn ? weak_t : weak_nt;   // first sighting starts weak
        end else begin
            case (cur)
                strong_nt: nxt = tkn ? weak_nt  : strong_nt;
                weak_nt:   nxt = tkn ? weak_t   : strong_nt;
                weak_t:    nxt = tkn ? strong_t : weak_nt;
                default:   nxt = tkn ? strong_t : weak_t;
            endcase
        end
        return nxt;
    endfunction

    assign rd_a_idx = lookup_pc[INDEX_BITS+1:2];
    assign rd_b_idx = resolve.pc[INDEX_BITS+1:2];

    // lookup, all combinational
    assign btb_hit    = btb_a_valid && (btb_a.tag == lookup_pc[31:32-TAG_BITS]);
    assign pred_taken = enable && bht_a_valid && bht_a.ctr[1] && btb_hit;

    assign lookup_rsp.hit    = btb_hit;
    assign lookup_rsp.taken  = pred_taken;
    assign lookup_rsp.target = pred_taken ? btb_a.target : lookup_pc + 32'd4;

    // training keeps going while prediction is disabled
    assign wr_idx          = resolve.pc[INDEX_BITS+1:2];
    assign bht_wr_en       = resolve.valid;
    assign bht_wr_data.ctr = ctr_next(bht_b.ctr, bht_b_valid, resolve.taken);

    assign btb_wr_en          = resolve.valid && resolve.taken;
    assign btb_wr_data.tag    = resolve.pc[31:32-TAG_BITS];
    assign btb_wr_data.target = resolve.target;

    // wrong direction, or taken to the wrong place
    assign miss = resolve.valid &&
                  ((resolve.taken != resolve.pred_taken) ||
                   (resolve.taken && (resolve.target != resolve.pred_target)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mispredict_q  <= 1'b0;
            resolve_evt_q <= 1'b0;
        end else begin
            mispredict_q  <= miss;
            resolve_evt_q <= resolve.valid;
        end
    end

    assign mispredict  = mispredict_q;
    assign miss_evt    = mispredict_q;   // same event feeds the miss counter
    assign resolve_evt = resolve_evt_q;

    a_miss_after_resolve: assert property (
        @(posedge clk) disable iff (!rst_n)
        mispredict |-> $past(resolve.valid)
    ) else $error("bpu_ctrl: mispredict without a preceding resolve");

endmodule

/* src/bpu_apb_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bpu APB registers
// control bits plus resolve and miss counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bpu_apb_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  bpu_pkg::apb_req_t apb_req,
    output bpu_pkg::apb_rsp_t apb_rsp,

    input  logic              resolve_evt,
    input  logic              miss_evt,
    output logic              enable,
    output logic              flush
);

    import bpu_pkg::*;

    logic        access;
    logic        wr_access;
    logic        addr_ok;
    logic [31:0] resolve_cnt;
    logic [31:0] miss_cnt;

    // single-cycle access phase, no wait states
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;

    assign addr_ok = (apb_req.paddr == REG_CTRL) ||
                     (apb_req.paddr == REG_RESOLVES) ||
                     (apb_req.paddr == REG_MISSES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b1;     // predictor on out of reset
            flush  <= 1'b0;
        end else begin
            flush <= wr_access && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[1];
            if (wr_access && apb_req.paddr == REG_CTRL) begin
                enable <= apb_req.pwdata[0];
            end
        end
    end

    // event counters wrap, any write clears them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resolve_cnt <= '0;
            miss_cnt    <= '0;
        end else begin
            if (wr_access && apb_req.paddr == REG_RESOLVES) begin
                resolve_cnt <= '0;
            end else if (resolve_evt) begin
                resolve_cnt <= resolve_cnt + 32'd1;
            end

            if (wr_access && apb_req.paddr == REG_MISSES) begin
                miss_cnt <= '0;
            end else if (miss_evt) begin
                miss_cnt <= miss_cnt + 32'd1;
            end
        end
    end

    // read mux
    always_comb begin
        case (apb_req.paddr)
            REG_CTRL:     apb_rsp.prdata = {31'd0, enable};  // flush reads back 0
            REG_RESOLVES: apb_rsp.prdata = resolve_cnt;
            REG_MISSES:   apb_rsp.prdata = miss_cnt;
            default:      apb_rsp.prdata = 32'd0;
        endcase
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && !addr_ok;

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel
    ) else $error("bpu_apb_regs: penable high without psel");

endmodule

/* src/pred_table.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// prediction table
// generic entry array with valid bits, two async reads,
// one sync write and a flush of all valid bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pred_table #(
    parameter type entry_t = logic [1:0]
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,

    // read ports
    input  logic [bpu_pkg::INDEX_BITS-1:0] rd_a_idx,
    input  logic [bpu_pkg::INDEX_BITS-1:0] rd_b_idx,
    output entry_t                        rd_a_data,
    output entry_t                        rd_b_data,
    output logic                          rd_a_valid,
    output logic                          rd_b_valid,

    // write port
    input  logic                          wr_en,
    input  logic [bpu_pkg::INDEX_BITS-1:0] wr_idx,
    input  entry_t                        wr_data
);

    import bpu_pkg::*;

    entry_t                 mem [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] valid_q;

    // entry storage, contents only mean something once valid
    always_ff @(posedge clk) begin
        if (wr_en && !flush) begin
            mem[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;      // flush wins over a write
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // lookup side
    assign rd_a_data  = mem[rd_a_idx];
    assign rd_a_valid = valid_q[rd_a_idx];

    // resolve side
    assign rd_b_data  = mem[rd_b_idx];
    assign rd_b_valid = valid_q[rd_b_idx];

    // an X write enable would corrupt the valid vector silently
    a_wr_en_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(wr_en)
    ) else $error("pred_table: wr_en is unknown");

endmodule

/* src/bpu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bpu package
// table sizes, counter encoding, entry and port structs,
// and APB register map of the branch prediction unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bpu_pkg;

    // tables are indexed by pc[9:2]
    localparam int INDEX_BITS  = 8;
    localparam int TABLE_DEPTH = 1 << INDEX_BITS;
    localparam int TAG_BITS    = 22;    // pc[31:10]

    // 2-bit saturating counter, msb is the predicted direction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_t;

    typedef struct packed {
        ctr_t ctr;
    } bht_entry_t;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [31:0]         target;
    } btb_entry_t;

    // answer to the fetch stage
    typedef struct packed {
        logic        hit;       // btb tag matched
        logic        taken;
        logic [31:0] target;
    } lookup_rsp_t;

    // outcome reported by the memory stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        pred_taken;    // what lookup said for this branch
        logic [31:0] pred_target;
    } resolve_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0] REG_CTRL     = 8'h00;   // [0] enable, [1] flush
    localparam logic [7:0] REG_RESOLVES = 8'h04;
    localparam logic [7:0] REG_MISSES   = 8'h08;

endpackage
